// File: hw/isa_pkg.sv
package isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;

	// primary opcode, inst[31:26]
	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_beq     = 6'h04,
		op_bne     = 6'h05,
		op_addiu   = 6'h09,
		op_andi    = 6'h0c,
		op_ori     = 6'h0d,
		op_lui     = 6'h0f,
		op_lw      = 6'h23,
		op_sw      = 6'h2b
	} opcode_e;

	// function field of special, inst[5:0]
	typedef enum logic [5:0] {
		fn_sll  = 6'h00,
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_xor  = 6'h26,
		fn_slt  = 6'h2a,
		fn_sltu = 6'h2b
	} funct_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sltu,
		alu_sll,
		alu_lui
	} alu_op_e;

endpackage

// File: hw/pipe_pkg.sv
package pipe_pkg;
	import isa_pkg::*;

	// fetch to decode
	typedef struct packed {
		word_t pc;
		word_t inst;
	} fetch_item_t;

	// decode to execute
	typedef struct packed {
		word_t    pc;
		alu_op_e  alu_op;
		word_t    src_a;
		word_t    src_b;
		word_t    store_data;
		reg_idx_t dest;
		logic     reg_write;
		logic     mem_read;
		logic     mem_write;
	} exec_item_t;

	// execute to memory
	typedef struct packed {
		word_t    pc;
		word_t    result;
		word_t    store_data;
		reg_idx_t dest;
		logic     reg_write;
		logic     mem_read;
		logic     mem_write;
	} mem_item_t;

	// memory to writeback
	typedef struct packed {
		word_t    pc;
		reg_idx_t dest;
		word_t    wdata;
		logic     reg_write;
	} retire_item_t;

endpackage

// File: hw/fetch_unit.sv
module fetch_unit import isa_pkg::*, pipe_pkg::*; #(
	parameter word_t reset_pc = 32'hbfc0_0000
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        de_allowin,
	input  logic        branch_taken,
	input  word_t       branch_target,
	output logic        inst_req,
	output word_t       inst_addr,
	input  word_t       inst_rdata,
	input  logic        inst_addr_ok,
	input  logic        inst_data_ok,
	output logic        fd_valid,
	output fetch_item_t fd_item
);

	word_t pc;
	word_t req_pc;
	word_t br_target;
	logic  br_pending;
	logic  data_wait;
	logic  addr_hs;
	logic  data_hs;

	// de_allowin is also high with the fd register empty, so a returned word has room
	assign inst_req  = ~data_wait & de_allowin;
	assign inst_addr = pc;
	assign addr_hs   = inst_req & inst_addr_ok;
	assign data_hs   = data_wait & inst_data_ok;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc         <= reset_pc;
			data_wait  <= 1'b0;
			br_pending <= 1'b0;
		end else begin
			if (addr_hs)
				data_wait <= 1'b1;
			else if (data_hs)
				data_wait <= 1'b0;

			// an accepted request after a taken branch is its delay slot
			if (addr_hs) begin
				if (branch_taken)
					pc <= branch_target;
				else if (br_pending)
					pc <= br_target;
				else
					pc <= pc + 32'd4;
				br_pending <= 1'b0;
			end else if (branch_taken) begin
				br_pending <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (addr_hs)
			req_pc <= pc;
		if (branch_taken)
			br_target <= branch_target;
	end

	always_ff @(posedge clk) begin
		if (reset)
			fd_valid <= 1'b0;
		else if (data_hs)
			fd_valid <= 1'b1;
		else if (de_allowin)
			fd_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (data_hs) begin
			fd_item.pc   <= req_pc;
			fd_item.inst <= inst_rdata;
		end
	end

endmodule

// File: hw/decode_stage.sv
module decode_stage import isa_pkg::*, pipe_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        fd_valid,
	input  fetch_item_t fd_item,
	output logic        de_allowin,
	input  logic        em_allowin,
	output reg_idx_t    rs_addr,
	output reg_idx_t    rt_addr,
	input  word_t       rs_data,
	input  word_t       rt_data,
	input  reg_idx_t    e_dest,
	input  logic        e_reg_write,
	input  reg_idx_t    m_dest,
	input  word_t       m_value,
	input  logic        m_pending,
	input  reg_idx_t    w_dest,
	input  word_t       w_value,
	input  logic        w_reg_write,
	output logic        branch_taken,
	output word_t       branch_target,
	output logic        de_valid,
	output exec_item_t  de_item
);

	reg_idx_t    rd;
	logic [4:0]  shamt;
	logic [15:0] imm;
	word_t       imm_ext;
	word_t       rs_value;
	word_t       rt_value;
	alu_op_e     alu_op;
	reg_idx_t    dest;
	logic        use_imm;
	logic        zero_ext;
	logic        use_shamt;
	logic        reg_write;
	logic        mem_read;
	logic        mem_write;
	logic        use_rs;
	logic        use_rt;
	logic        is_beq;
	logic        is_bne;
	logic        stall;
	logic        leave;

	assign rs_addr = fd_item.inst[25:21];
	assign rt_addr = fd_item.inst[20:16];
	assign rd      = fd_item.inst[15:11];
	assign shamt   = fd_item.inst[10:6];
	assign imm     = fd_item.inst[15:0];
	assign imm_ext = zero_ext ? {16'h0, imm} : {{16{imm[15]}}, imm};

	always_comb begin
		alu_op    = alu_add;
		dest      = rt_addr;
		use_imm   = 1'b0;
		zero_ext  = 1'b0;
		use_shamt = 1'b0;
		reg_write = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		use_rs    = 1'b0;
		use_rt    = 1'b0;
		is_beq    = 1'b0;
		is_bne    = 1'b0;
		case (opcode_e'(fd_item.inst[31:26]))
			op_special: begin
				dest      = rd;
				use_rs    = 1'b1;
				use_rt    = 1'b1;
				reg_write = 1'b1;
				case (funct_e'(fd_item.inst[5:0]))
					fn_addu: alu_op = alu_add;
					fn_subu: alu_op = alu_sub;
					fn_and:  alu_op = alu_and;
					fn_or:   alu_op = alu_or;
					fn_xor:  alu_op = alu_xor;
					fn_slt:  alu_op = alu_slt;
					fn_sltu: alu_op = alu_sltu;
					fn_sll: begin
						alu_op    = alu_sll;
						use_shamt = 1'b1;
						use_rs    = 1'b0;
					end
					default: begin
						use_rs    = 1'b0;
						use_rt    = 1'b0;
						reg_write = 1'b0;
					end
				endcase
			end
			op_addiu: begin
				use_imm   = 1'b1;
				use_rs    = 1'b1;
				reg_write = 1'b1;
			end
			op_andi, op_ori: begin
				alu_op    = (fd_item.inst[26]) ? alu_or : alu_and;
				use_imm   = 1'b1;
				zero_ext  = 1'b1;
				use_rs    = 1'b1;
				reg_write = 1'b1;
			end
			op_lui: begin
				alu_op    = alu_lui;
				use_imm   = 1'b1;
				reg_write = 1'b1;
			end
			op_lw: begin
				use_imm   = 1'b1;
				use_rs    = 1'b1;
				reg_write = 1'b1;
				mem_read  = 1'b1;
			end
			op_sw: begin
				use_imm   = 1'b1;
				use_rs    = 1'b1;
				use_rt    = 1'b1;
				mem_write = 1'b1;
			end
			op_beq, op_bne: begin
				use_rs = 1'b1;
				use_rt = 1'b1;
				is_beq = ~fd_item.inst[26];
				is_bne = fd_item.inst[26];
			end
			default: ;
		endcase
	end

	// memory stage first, it holds the younger result
	function automatic word_t pick(input reg_idx_t src, input word_t rf_value);
		word_t value;
		value = rf_value;
		if (src != '0 && m_dest == src)
			value = m_value;
		else if (src != '0 && w_reg_write && w_dest == src)
			value = w_value;
		return value;
	endfunction

	// no path out of execute, and a load in memory may still be waiting
	function automatic logic must_wait(input reg_idx_t src);
		return src != '0 && ((e_reg_write && e_dest == src) || (m_pending && m_dest == src));
	endfunction

	always_comb begin
		rs_value = pick(rs_addr, rs_data);
		rt_value = pick(rt_addr, rt_data);
		stall    = fd_valid && ((use_rs && must_wait(rs_addr)) || (use_rt && must_wait(rt_addr)));
	end

	assign leave         = fd_valid & ~stall & em_allowin;
	assign de_allowin    = ~fd_valid | leave;
	assign branch_target = fd_item.pc + 32'd4 + {imm_ext[29:0], 2'b00};
	assign branch_taken  = leave & ((is_beq & (rs_value == rt_value)) |
		(is_bne & (rs_value != rt_value)));

	always_ff @(posedge clk) begin
		if (reset)
			de_valid <= 1'b0;
		else if (em_allowin)
			de_valid <= leave;
	end

	always_ff @(posedge clk) begin
		if (leave) begin
			de_item.pc         <= fd_item.pc;
			de_item.alu_op     <= alu_op;
			de_item.src_a      <= use_shamt ? {27'h0, shamt} : rs_value;
			de_item.src_b      <= use_imm ? imm_ext : rt_value;
			de_item.store_data <= rt_value;
			de_item.dest       <= dest;
			// r0 results are dropped here so they never forward or trace
			de_item.reg_write  <= reg_write & (dest != '0);
			de_item.mem_read   <= mem_read;
			de_item.mem_write  <= mem_write;
		end
	end

endmodule

// File: hw/reg_file.sv
module reg_file import isa_pkg::*; (
	input  logic     clk,
	input  reg_idx_t rs_addr,
	input  reg_idx_t rt_addr,
	output word_t    rs_data,
	output word_t    rt_data,
	input  logic     w_reg_write,
	input  reg_idx_t w_dest,
	input  word_t    w_value
);

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (w_reg_write && w_dest != '0)
			regs[w_dest] <= w_value;
	end

	// entry 0 is never written, so read it as zero
	assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

// File: hw/execute_stage.sv
module execute_stage import isa_pkg::*, pipe_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       de_valid,
	input  exec_item_t de_item,
	output logic       em_allowin,
	input  logic       mw_allowin,
	output reg_idx_t   e_dest,
	output logic       e_reg_write,
	output logic       em_valid,
	output mem_item_t  em_item
);

	word_t a;
	word_t b;
	word_t result;

	assign a = de_item.src_a;
	assign b = de_item.src_b;

	always_comb begin
		case (de_item.alu_op)
			alu_add:  result = a + b;
			alu_sub:  result = a - b;
			alu_and:  result = a & b;
			alu_or:   result = a | b;
			alu_xor:  result = a ^ b;
			alu_slt:  result = {31'h0, $signed(a) < $signed(b)};
			alu_sltu: result = {31'h0, a < b};
			// shamt arrives in a
			alu_sll:  result = b << a[4:0];
			alu_lui:  result = {b[15:0], 16'h0};
			default:  result = a + b;
		endcase
	end

	// single cycle, never stalls on its own
	assign em_allowin  = ~de_valid | mw_allowin;
	assign e_dest      = de_item.dest;
	assign e_reg_write = de_valid & de_item.reg_write;

	always_ff @(posedge clk) begin
		if (reset)
			em_valid <= 1'b0;
		else if (mw_allowin)
			em_valid <= de_valid;
	end

	always_ff @(posedge clk) begin
		if (mw_allowin && de_valid) begin
			em_item.pc         <= de_item.pc;
			em_item.result     <= result;
			em_item.store_data <= de_item.store_data;
			em_item.dest       <= de_item.dest;
			em_item.reg_write  <= de_item.reg_write;
			em_item.mem_read   <= de_item.mem_read;
			em_item.mem_write  <= de_item.mem_write;
		end
	end

endmodule

// File: hw/mem_stage.sv
module mem_stage import isa_pkg::*, pipe_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       em_valid,
	input  mem_item_t  em_item,
	output logic       mw_allowin,
	output logic       data_req,
	output logic       data_wr,
	output word_t      data_addr,
	output word_t      data_wdata,
	input  word_t      data_rdata,
	input  logic       data_addr_ok,
	input  logic       data_data_ok,
	output reg_idx_t   m_dest,
	output word_t      m_value,
	output logic       m_pending,
	output reg_idx_t   w_dest,
	output word_t      w_value,
	output logic       w_reg_write,
	output word_t      debug_wb_pc,
	output logic [3:0] debug_wb_rf_wen,
	output reg_idx_t   debug_wb_rf_wnum,
	output word_t      debug_wb_rf_wdata
);

	logic         is_access;
	logic         data_wait;
	logic         access_done;
	logic         stall;
	logic         w_valid;
	retire_item_t w_item;

	assign is_access   = em_valid & (em_item.mem_read | em_item.mem_write);
	assign access_done = data_wait & data_data_ok;
	assign stall       = is_access & ~access_done;
	assign mw_allowin  = ~em_valid | ~stall;

	assign data_req   = is_access & ~data_wait;
	assign data_wr    = em_item.mem_write;
	assign data_addr  = em_item.result;
	assign data_wdata = em_item.store_data;

	always_ff @(posedge clk) begin
		if (reset)
			data_wait <= 1'b0;
		else if (data_req && data_addr_ok)
			data_wait <= 1'b1;
		else if (access_done)
			data_wait <= 1'b0;
	end

	// dest reads as r0 when nothing here will write
	assign m_dest    = (em_valid && em_item.reg_write) ? em_item.dest : '0;
	assign m_value   = em_item.mem_read ? data_rdata : em_item.result;
	assign m_pending = em_valid & em_item.mem_read & ~access_done;

	always_ff @(posedge clk) begin
		if (reset)
			w_valid <= 1'b0;
		else
			w_valid <= em_valid & ~stall;
	end

	always_ff @(posedge clk) begin
		if (em_valid && !stall) begin
			w_item.pc        <= em_item.pc;
			w_item.dest      <= em_item.dest;
			w_item.wdata     <= m_value;
			w_item.reg_write <= em_item.reg_write;
		end
	end

	assign w_dest      = w_item.dest;
	assign w_value     = w_item.wdata;
	assign w_reg_write = w_valid & w_item.reg_write;

	assign debug_wb_pc       = w_item.pc;
	assign debug_wb_rf_wen   = {4{w_reg_write}};
	assign debug_wb_rf_wnum  = w_item.dest;
	assign debug_wb_rf_wdata = w_item.wdata;

endmodule

// File: hw/mips_core.sv
module mips_core import isa_pkg::*, pipe_pkg::*; #(
	parameter word_t reset_pc = 32'hbfc0_0000
) (
	input  logic       clk,
	input  logic       reset,
	output logic       inst_req,
	output logic       inst_wr,
	output logic [1:0] inst_size,
	output word_t      inst_addr,
	output word_t      inst_wdata,
	input  word_t      inst_rdata,
	input  logic       inst_addr_ok,
	input  logic       inst_data_ok,
	output logic       data_req,
	output logic       data_wr,
	output logic [1:0] data_size,
	output word_t      data_addr,
	output word_t      data_wdata,
	input  word_t      data_rdata,
	input  logic       data_addr_ok,
	input  logic       data_data_ok,
	output word_t      debug_wb_pc,
	output logic [3:0] debug_wb_rf_wen,
	output reg_idx_t   debug_wb_rf_wnum,
	output word_t      debug_wb_rf_wdata
);

	logic        fd_valid;
	fetch_item_t fd_item;
	logic        de_allowin;
	logic        branch_taken;
	word_t       branch_target;
	reg_idx_t    rs_addr;
	reg_idx_t    rt_addr;
	word_t       rs_data;
	word_t       rt_data;
	logic        de_valid;
	exec_item_t  de_item;
	logic        em_allowin;
	reg_idx_t    e_dest;
	logic        e_reg_write;
	logic        em_valid;
	mem_item_t   em_item;
	logic        mw_allowin;
	reg_idx_t    m_dest;
	word_t       m_value;
	logic        m_pending;
	reg_idx_t    w_dest;
	word_t       w_value;
	logic        w_reg_write;

	// instruction side is read only, always full words
	assign inst_wr    = 1'b0;
	assign inst_size  = 2'b10;
	assign inst_wdata = '0;
	assign data_size  = 2'b10;

	fetch_unit #(
		.reset_pc(reset_pc)
	) fetch_unit_i (
		.clk, .reset, .de_allowin, .branch_taken, .branch_target,
		.inst_req, .inst_addr, .inst_rdata, .inst_addr_ok, .inst_data_ok,
		.fd_valid, .fd_item
	);

	decode_stage decode_stage_i (
		.clk, .reset, .fd_valid, .fd_item, .de_allowin, .em_allowin,
		.rs_addr, .rt_addr, .rs_data, .rt_data,
		.e_dest, .e_reg_write, .m_dest, .m_value, .m_pending,
		.w_dest, .w_value, .w_reg_write,
		.branch_taken, .branch_target, .de_valid, .de_item
	);

	reg_file reg_file_i (
		.clk, .rs_addr, .rt_addr, .rs_data, .rt_data,
		.w_reg_write, .w_dest, .w_value
	);

	execute_stage execute_stage_i (
		.clk, .reset, .de_valid, .de_item, .em_allowin, .mw_allowin,
		.e_dest, .e_reg_write, .em_valid, .em_item
	);

	mem_stage mem_stage_i (
		.clk, .reset, .em_valid, .em_item, .mw_allowin,
		.data_req, .data_wr, .data_addr, .data_wdata, .data_rdata,
		.data_addr_ok, .data_data_ok,
		.m_dest, .m_value, .m_pending, .w_dest, .w_value, .w_reg_write,
		.debug_wb_pc, .debug_wb_rf_wen, .debug_wb_rf_wnum, .debug_wb_rf_wdata
	);

endmodule

// File: testbench/tb_sram_model.sv
module tb_sram_model import isa_pkg::*; #(
	parameter int seed = 1
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  inst_req,
	input  word_t inst_addr,
	output word_t inst_rdata,
	output logic  inst_addr_ok,
	output logic  inst_data_ok,
	input  logic  data_req,
	input  logic  data_wr,
	input  word_t data_addr,
	input  word_t data_wdata,
	output word_t data_rdata,
	output logic  data_addr_ok,
	output logic  data_data_ok
);
	timeunit 1ns;
	timeprecision 100ps;

	word_t imem [1024];
	word_t dmem [1024];
	logic  i_busy;
	logic  d_busy;
	int    i_cnt;
	int    d_cnt;
	word_t i_addr;
	word_t d_addr;
	logic  seeded = 1'b0;

	function automatic int draw_delay();
		return $urandom_range(3, 0);
	endfunction

	initial begin
		inst_rdata   = '0;
		inst_addr_ok = 1'b0;
		inst_data_ok = 1'b0;
		data_rdata   = '0;
		data_addr_ok = 1'b0;
		data_data_ok = 1'b0;
	end

	// both ports in one process so a single seed covers every draw
	always @(posedge clk) begin
		if (!seeded) begin
			void'($urandom(seed));
			seeded = 1'b1;
		end
		if (reset) begin
			i_busy = 1'b0;
			d_busy = 1'b0;
			i_cnt  = 0;
			d_cnt  = 0;
		end else begin
			if (inst_data_ok) begin
				i_busy = 1'b0;
				i_cnt  = draw_delay();
			end else if (inst_req && inst_addr_ok) begin
				i_busy = 1'b1;
				i_addr = inst_addr;
				i_cnt  = draw_delay();
			end else if (i_cnt != 0) begin
				i_cnt--;
			end
			if (data_data_ok) begin
				d_busy = 1'b0;
				d_cnt  = draw_delay();
			end else if (data_req && data_addr_ok) begin
				d_busy = 1'b1;
				d_addr = data_addr;
				// stores land when accepted
				if (data_wr)
					dmem[data_addr[11:2]] = data_wdata;
				d_cnt = draw_delay();
			end else if (d_cnt != 0) begin
				d_cnt--;
			end
		end
		#1;
		inst_addr_ok = !reset && !i_busy && i_cnt == 0;
		inst_data_ok = !reset && i_busy && i_cnt == 0;
		if (inst_data_ok)
			inst_rdata = imem[i_addr[11:2]];
		data_addr_ok = !reset && !d_busy && d_cnt == 0;
		data_data_ok = !reset && d_busy && d_cnt == 0;
		if (data_data_ok)
			data_rdata = dmem[d_addr[11:2]];
	end

endmodule

// File: testbench/tb_mips_core.sv
module tb_mips_core import isa_pkg::*;;
	timeunit 1ns;
	timeprecision 100ps;

	logic       clk;
	logic       reset;
	logic       inst_req;
	logic       inst_wr;
	logic [1:0] inst_size;
	word_t      inst_addr;
	word_t      inst_wdata;
	word_t      inst_rdata;
	logic       inst_addr_ok;
	logic       inst_data_ok;
	logic       data_req;
	logic       data_wr;
	logic [1:0] data_size;
	word_t      data_addr;
	word_t      data_wdata;
	word_t      data_rdata;
	logic       data_addr_ok;
	logic       data_data_ok;
	word_t      debug_wb_pc;
	logic [3:0] debug_wb_rf_wen;
	reg_idx_t   debug_wb_rf_wnum;
	word_t      debug_wb_rf_wdata;

	word_t prog [64];
	int    prog_len = 0;
	word_t model_mem [1024];
	word_t exp_pc [64];
	int    exp_reg [64];
	word_t exp_val [64];
	int    exp_count = 0;
	int    retire_idx = 0;
	int    cycles = 0;
	int    limit;
	int    trace_errors = 0;
	int    port_errors = 0;
	int    mem_errors = 0;
	int    timed_out = 0;

	mips_core #(.reset_pc(32'h0)) mips_core_i (.*);
	tb_sram_model #(.seed(41290)) memory_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		if (reset) begin
			retire_idx <= 0;
			cycles     <= 0;
		end else begin
			cycles <= cycles + 1;
			if (debug_wb_rf_wen == 4'hf)
				retire_idx <= retire_idx + 1;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		debug_wb_rf_wen != 4'h0 |-> debug_wb_rf_wen == 4'hf && retire_idx < exp_count)
	else begin
		trace_errors++;
		$display("unexpected register write at %0t, wen %b after %0d of %0d writes",
			$time, $sampled(debug_wb_rf_wen), $sampled(retire_idx), exp_count);
	end

	assert property (@(posedge clk) disable iff (reset)
		debug_wb_rf_wen == 4'hf && retire_idx < exp_count |-> debug_wb_pc == exp_pc[retire_idx])
	else begin
		trace_errors++;
		$display("Error at %0t: debug_wb_pc = %h, expected %h",
			$time, $sampled(debug_wb_pc), exp_pc[$sampled(retire_idx)]);
	end

	assert property (@(posedge clk) disable iff (reset)
		debug_wb_rf_wen == 4'hf && retire_idx < exp_count
		|-> debug_wb_rf_wnum == exp_reg[retire_idx])
	else begin
		trace_errors++;
		$display("Error at %0t: debug_wb_rf_wnum = %0d, expected %0d",
			$time, $sampled(debug_wb_rf_wnum), exp_reg[$sampled(retire_idx)]);
	end

	assert property (@(posedge clk) disable iff (reset)
		debug_wb_rf_wen == 4'hf && retire_idx < exp_count
		|-> debug_wb_rf_wdata == exp_val[retire_idx])
	else begin
		trace_errors++;
		$display("Error at %0t: debug_wb_rf_wdata = %h, expected %h",
			$time, $sampled(debug_wb_rf_wdata), exp_val[$sampled(retire_idx)]);
	end

	// instruction port only reads
	assert property (@(posedge clk) disable iff (reset) inst_req |-> inst_wr == 1'b0)
	else begin
		port_errors++;
		$display("Error at %0t: inst_wr = %b, expected 0", $time, $sampled(inst_wr));
	end

	// both ports move full words
	assert property (@(posedge clk) disable iff (reset) inst_req |-> inst_size == 2'b10)
	else begin
		port_errors++;
		$display("Error at %0t: inst_size = %b, expected 10", $time, $sampled(inst_size));
	end

	assert property (@(posedge clk) disable iff (reset) data_req |-> data_size == 2'b10)
	else begin
		port_errors++;
		$display("Error at %0t: data_size = %b, expected 10", $time, $sampled(data_size));
	end

	assert property (@(posedge clk) disable iff (reset)
		!$isunknown(inst_wdata) && $stable(inst_wdata))
	else begin
		port_errors++;
		$display("inst_wdata is not a steady known value at %0t, now %h",
			$time, $sampled(inst_wdata));
	end

	function automatic word_t r_word(funct_e fn, int rd, int rs, int rt, int sh);
		return {op_special, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
	endfunction

	function automatic word_t i_word(opcode_e op, int rt, int rs, int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic word_t dmem_fill(int k);
		word_t byte_addr;
		byte_addr = k * 4;
		return 32'h3c5a_0000 ^ (byte_addr * 32'h9e37_79b9);
	endfunction

	task automatic add_inst(word_t w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	task automatic build_program();
		add_inst(i_word(op_lui, 1, 0, 16'h8000));
		add_inst(i_word(op_ori, 1, 1, 16'h0005));
		add_inst(i_word(op_addiu, 2, 0, 7));
		// signed and unsigned compare of a negative value
		add_inst(r_word(fn_slt, 3, 1, 2, 0));
		add_inst(r_word(fn_sltu, 4, 1, 2, 0));
		add_inst(r_word(fn_subu, 5, 2, 1, 0));
		add_inst(r_word(fn_xor, 6, 5, 1, 0));
		add_inst(r_word(fn_and, 7, 6, 2, 0));
		add_inst(r_word(fn_or, 9, 7, 1, 0));
		add_inst(r_word(fn_sll, 10, 0, 2, 4));
		add_inst(i_word(op_andi, 11, 1, 16'hff05));
		add_inst(i_word(op_addiu, 8, 0, 16'h0100));
		add_inst(i_word(op_sw, 10, 8, 0));
		add_inst(i_word(op_lw, 12, 8, 0));
		add_inst(r_word(fn_addu, 13, 12, 2, 0));
		add_inst(i_word(op_addiu, 0, 0, 5));
		add_inst(r_word(fn_addu, 14, 0, 2, 0));
		add_inst(i_word(op_beq, 2, 14, 3));
		add_inst(i_word(op_addiu, 15, 0, 1));
		add_inst(i_word(op_addiu, 16, 0, 2));
		add_inst(i_word(op_addiu, 17, 0, 3));
		add_inst(i_word(op_bne, 15, 15, 2));
		add_inst(i_word(op_addiu, 18, 0, 4));
		add_inst(i_word(op_addiu, 19, 0, 5));
		add_inst(i_word(op_sw, 13, 8, 4));
		add_inst(i_word(op_addiu, 20, 0, -1));
		add_inst(i_word(op_sw, 20, 8, 8));
		add_inst(i_word(op_lw, 21, 8, 8));
		add_inst(r_word(fn_addu, 22, 21, 21, 0));
		add_inst(r_word(fn_slt, 23, 20, 0, 0));
		add_inst(r_word(fn_sltu, 24, 0, 20, 0));
		// untouched word still holds the fill value
		add_inst(i_word(op_lw, 25, 8, 12));
		add_inst(r_word(fn_addu, 26, 25, 2, 0));
	endtask

	// instruction level model with one delay slot per branch
	task automatic run_model();
		word_t      regs [32];
		word_t      pc;
		word_t      npc;
		word_t      cur;
		word_t      inst;
		word_t      a;
		word_t      b;
		word_t      simm;
		word_t      addr;
		word_t      val;
		logic [4:0] dst;
		logic       wr;
		foreach (regs[k])
			regs[k] = '0;
		pc  = '0;
		npc = 32'd4;
		while (pc < prog_len * 4) begin
			cur  = pc;
			inst = prog[cur[31:2]];
			pc   = npc;
			npc  = npc + 32'd4;
			a    = regs[inst[25:21]];
			b    = regs[inst[20:16]];
			simm = {{16{inst[15]}}, inst[15:0]};
			addr = a + simm;
			dst  = inst[20:16];
			wr   = 1'b1;
			val  = '0;
			case (inst[31:26])
				6'h00: begin
					dst = inst[15:11];
					case (inst[5:0])
						6'h00: val = b << inst[10:6];
						6'h21: val = a + b;
						6'h23: val = a - b;
						6'h24: val = a & b;
						6'h25: val = a | b;
						6'h26: val = a ^ b;
						6'h2a: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						6'h2b: val = (a < b) ? 32'd1 : 32'd0;
						default: wr = 1'b0;
					endcase
				end
				6'h09: val = a + simm;
				6'h0c: val = a & {16'h0, inst[15:0]};
				6'h0d: val = a | {16'h0, inst[15:0]};
				6'h0f: val = {inst[15:0], 16'h0};
				6'h23: val = model_mem[addr[11:2]];
				6'h2b: begin
					wr = 1'b0;
					model_mem[addr[11:2]] = b;
				end
				6'h04, 6'h05: begin
					wr = 1'b0;
					if ((a == b) != inst[26])
						npc = cur + 32'd4 + {simm[29:0], 2'b00};
				end
				default: wr = 1'b0;
			endcase
			if (wr && dst != 0) begin
				regs[dst]          = val;
				exp_pc[exp_count]  = cur;
				exp_reg[exp_count] = dst;
				exp_val[exp_count] = val;
				exp_count++;
			end
		end
	endtask

	task automatic check_memory();
		for (int k = 0; k < 1024; k++) begin
			assert (memory_i.dmem[k] == model_mem[k])
			else begin
				mem_errors++;
				$display("Error at %0t: dmem[%0d] = %h, expected %h",
					$time, k, memory_i.dmem[k], model_mem[k]);
			end
		end
	endtask

	initial begin
		reset = 1'b1;
		build_program();
		for (int k = 0; k < 1024; k++) begin
			memory_i.imem[k] = (k < prog_len) ? prog[k] : '0;
			memory_i.dmem[k] = dmem_fill(k);
			model_mem[k]     = dmem_fill(k);
		end
		run_model();
		limit = 40 * exp_count;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		while (retire_idx < exp_count && cycles < limit)
			@(posedge clk);
		if (retire_idx < exp_count) begin
			timed_out = 1;
			$display("timeout: %0d of %0d register writes retired within %0d cycles",
				retire_idx, exp_count, limit);
		end else begin
			// a few more cycles so any stray write is caught
			repeat (4) @(posedge clk);
			check_memory();
		end
		$display("errors: trace %0d, port %0d, memory %0d, timeout %0d",
			trace_errors, port_errors, mem_errors, timed_out);
		if (trace_errors == 0 && port_errors == 0 && mem_errors == 0 && timed_out == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: sources.f
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/fetch_unit.sv
hw/decode_stage.sv
hw/reg_file.sv
hw/execute_stage.sv
hw/mem_stage.sv
hw/mips_core.sv
testbench/tb_sram_model.sv
testbench/tb_mips_core.sv
